// ==== rtl/sha_pkg.sv ====
package sha_pkg;

  // ----------------------------------------------------------------------
  // system bus
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [19:0] addr;   // byte offset inside the coprocessor window
    logic [31:0] wdata;
    logic        wen;    // write strobe, one cycle per word
    logic        ren;    // read strobe
  } sys_bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;    // tied low
    logic        ack;    // one cycle after each request cycle
  } sys_bus_rsp_t;

  // register map, byte offsets
  typedef enum logic [19:0] {
    REG_CTRL          = 20'h00000,
    REG_STATUS        = 20'h00004,
    REG_VERSION       = 20'h0000C,
    REG_SHA_CTRL      = 20'h00100,
    REG_SHA_STATUS    = 20'h00104,
    REG_SHA_PUSH      = 20'h0010C,
    REG_SHA_HASH_BASE = 20'h00110   // H7 here, up to H0 at 0x12C
  } reg_addr_e;

  localparam int CTRL_ENABLE    = 0;  // REG_CTRL
  localparam int SHA_CTRL_RESET = 0;  // REG_SHA_CTRL, self clearing
  localparam int SHA_CTRL_START = 1;  // REG_SHA_CTRL, self clearing

  // ----------------------------------------------------------------------
  // sha-256 section
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic ready;       // core idle
    logic hash_valid;
    logic blk_full;
    logic blk_empty;
  } sha_status_t;

  typedef enum logic [1:0] {
    IDLE,
    ROUND,
    UPDATE
  } sha_state_e;

  localparam int BLOCK_WORDS = 16;  // 512 bit block

  // element 0 is the most significant word
  localparam logic [0:7][31:0] SHA_IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  localparam logic [0:63][31:0] SHA_K = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

endpackage

// ==== rtl/sys_bus_regs.sv ====
`timescale 1ns/1ns

module sys_bus_regs #(
  parameter logic [31:0] BUILD_DATE = 32'h00000000  // 0xYYMMDDss
) (
  input  logic                  clk_100mhz,
  input  logic                  rstn_i,
  input  sha_pkg::sys_bus_req_t bus_req_i,
  input  sha_pkg::sha_status_t  sha_status_i,
  input  logic [255:0]          hash_i,       // H0 in the top word
  output sha_pkg::sys_bus_rsp_t bus_rsp_o,
  output logic                  activated_o,
  output logic                  sha_run_o,    // active low reset of the sha blocks
  output logic                  start_o,
  output logic                  push_valid_o,
  output logic [31:0]           push_word_o
);

  localparam logic [2:0] ACT_DONE = 3'd4;  // cycles from enable to release

  logic [31:0]      ctrl_q;
  logic [31:0]      sha_ctrl_q;
  logic [2:0]       act_cnt_q;
  logic             push_valid_q;
  logic [31:0]      push_word_q;
  logic             hash_valid_q;   // for edge detect
  logic [7:0][31:0] hash_q;         // index 0 is H7 at 0x110
  logic             ack_q;
  logic [31:0]      rdata_q;
  logic [31:0]      status_word;
  logic [31:0]      sha_status_word;
  logic [19:0]      hash_off;
  logic             hash_hit;

  // ----------------------------------------------------------------------
  // write decode
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      ctrl_q       <= '0;
      sha_ctrl_q   <= '0;
      push_valid_q <= 1'b0;
    end else begin
      sha_ctrl_q[3:0] <= 4'h0;  // reset and start live one cycle
      push_valid_q    <= 1'b0;
      if (bus_req_i.wen) begin
        case (bus_req_i.addr)
          sha_pkg::REG_CTRL:     ctrl_q       <= bus_req_i.wdata;
          sha_pkg::REG_SHA_CTRL: sha_ctrl_q   <= bus_req_i.wdata;
          sha_pkg::REG_SHA_PUSH: push_valid_q <= 1'b1;  // strobe to assembler
          default: ;                                     // writes elsewhere ignored
        endcase
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (bus_req_i.wen && bus_req_i.addr == sha_pkg::REG_SHA_PUSH) begin
      push_word_q <= bus_req_i.wdata;
    end
  end

  assign push_valid_o = push_valid_q;
  assign push_word_o  = push_word_q;
  assign start_o      = sha_ctrl_q[sha_pkg::SHA_CTRL_START];

  // ----------------------------------------------------------------------
  // activation sequence
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      act_cnt_q <= '0;
    end else if (!ctrl_q[sha_pkg::CTRL_ENABLE]) begin
      act_cnt_q <= '0;                // drop out one cycle after disable
    end else if (act_cnt_q != ACT_DONE) begin
      act_cnt_q <= act_cnt_q + 3'd1;
    end
  end

  assign activated_o = (act_cnt_q == ACT_DONE);
  assign sha_run_o   = activated_o && !sha_ctrl_q[sha_pkg::SHA_CTRL_RESET];

  // hash capture on rising hash_valid
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      hash_valid_q <= 1'b0;
    end else begin
      hash_valid_q <= sha_status_i.hash_valid;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sha_status_i.hash_valid && !hash_valid_q) begin
      hash_q <= hash_i;
    end
  end

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------

  assign status_word     = {27'b0, sha_run_o, 3'b0, activated_o};
  assign sha_status_word = {25'b0, sha_status_i.blk_full, 1'b0, sha_status_i.blk_empty,
                            2'b0, sha_status_i.hash_valid, sha_status_i.ready};

  assign hash_off = bus_req_i.addr - sha_pkg::REG_SHA_HASH_BASE;
  assign hash_hit = (hash_off < 20'd32) && (hash_off[1:0] == 2'b00);  // eight words

  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req_i.wen || bus_req_i.ren;  // every request acked next cycle
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (bus_req_i.ren) begin
      case (bus_req_i.addr)
        sha_pkg::REG_CTRL:       rdata_q <= ctrl_q;
        sha_pkg::REG_STATUS:     rdata_q <= status_word;
        sha_pkg::REG_VERSION:    rdata_q <= BUILD_DATE;
        sha_pkg::REG_SHA_CTRL:   rdata_q <= {sha_ctrl_q[31:4], 4'h0};  // pulse bits hidden
        sha_pkg::REG_SHA_STATUS: rdata_q <= sha_status_word;
        sha_pkg::REG_SHA_PUSH:   rdata_q <= '0;                      // write only
        default: begin
          rdata_q <= hash_hit ? hash_q[hash_off[4:2]] : 32'h0;      // unmapped reads zero
        end
      endcase
    end
  end

  assign bus_rsp_o.rdata = rdata_q;
  assign bus_rsp_o.err   = 1'b0;
  assign bus_rsp_o.ack   = ack_q;

  // release only after enable held through the whole count
  a_act_after_enable : assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    $rose(activated_o) |-> $past(ctrl_q[sha_pkg::CTRL_ENABLE], 4));

endmodule

// ==== rtl/block_assembler.sv ====
`timescale 1ns/1ns

module block_assembler (
  input  logic         clk_100mhz,
  input  logic         rstn_i,       // sha_run, low while disabled or reset
  input  logic         push_valid_i,
  input  logic [31:0]  push_word_i,
  input  logic         take_i,       // core grabs the block
  output logic [511:0] block_o,      // first word pushed in the top bits
  output logic         full_o,
  output logic         empty_o
);

  localparam int CNT_W = $clog2(sha_pkg::BLOCK_WORDS + 1);

  logic [CNT_W-1:0] word_cnt_q;
  logic [511:0]     block_q;
  logic             push_ok;

  assign push_ok = push_valid_i && !full_o;  // pushes into a full block are lost

  // ----------------------------------------------------------------------
  // word counter
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      word_cnt_q <= '0;
    end else if (take_i) begin
      word_cnt_q <= '0;                     // block handed over
    end else if (push_ok) begin
      word_cnt_q <= word_cnt_q + 1'b1;
    end
  end

  // shift register, no reset on payload
  always_ff @(posedge clk_100mhz) begin
    if (push_ok) begin
      block_q <= {block_q[479:0], push_word_i};  // older words move up
    end
  end

  assign block_o = block_q;
  assign full_o  = (word_cnt_q == CNT_W'(sha_pkg::BLOCK_WORDS));
  assign empty_o = (word_cnt_q == '0);

  // count stays within one block
  a_cnt_range : assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    word_cnt_q <= CNT_W'(sha_pkg::BLOCK_WORDS));

endmodule

// ==== rtl/sha256_core.sv ====
`timescale 1ns/1ns

module sha256_core (
  input  logic         clk_100mhz,
  input  logic         rstn_i,     // sha_run
  input  logic         start_i,    // reload IV
  input  logic [511:0] block_i,
  input  logic         full_i,
  output logic         take_o,
  output logic         ready_o,
  output logic         valid_o,
  output logic [255:0] hash_o      // H0 in the top word
);

  sha_pkg::sha_state_e state_q;
  logic [5:0]          round_q;
  logic                valid_q;
  logic [0:7][31:0]    chain_q;    // running hash H0..H7
  logic [0:7][31:0]    chain_src;
  logic [0:15][31:0]   w_q;        // w_q[0] is W of the current round
  logic [31:0]         a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q;
  logic [31:0]         t1, t2;
  logic [31:0]         w_next;

  function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic logic [31:0] big_s0(input logic [31:0] x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic logic [31:0] big_s1(input logic [31:0] x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic logic [31:0] small_s0(input logic [31:0] x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [31:0] small_s1(input logic [31:0] x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  // ----------------------------------------------------------------------
  // round logic
  // ----------------------------------------------------------------------

  always_comb begin
    t1 = h_q + big_s1(e_q) + ((e_q & f_q) ^ (~e_q & g_q))  // ch
       + sha_pkg::SHA_K[round_q] + w_q[0];
    t2 = big_s0(a_q) + ((a_q & b_q) ^ (a_q & c_q) ^ (b_q & c_q));  // maj
    // W[t+16] out of the rolling window
    w_next = small_s1(w_q[14]) + w_q[9] + small_s0(w_q[1]) + w_q[0];
  end

  assign chain_src = start_i ? sha_pkg::SHA_IV : chain_q;  // start with a block in hand
  assign take_o    = (state_q == sha_pkg::IDLE) && full_i;
  assign ready_o   = (state_q == sha_pkg::IDLE);
  assign valid_o   = valid_q;
  assign hash_o    = chain_q;

  // ----------------------------------------------------------------------
  // FSM and chaining value
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      state_q <= sha_pkg::IDLE;
      round_q <= '0;
      valid_q <= 1'b0;
      chain_q <= sha_pkg::SHA_IV;
    end else begin
      if (start_i) begin
        chain_q <= sha_pkg::SHA_IV;  // new message
        valid_q <= 1'b0;
      end
      case (state_q)
        sha_pkg::IDLE: begin
          if (full_i) begin
            state_q <= sha_pkg::ROUND;
            round_q <= '0;
            valid_q <= 1'b0;         // old hash gone with next block
          end
        end
        sha_pkg::ROUND: begin
          round_q <= round_q + 6'd1;
          if (round_q == 6'd63) begin
            state_q <= sha_pkg::UPDATE;
          end
        end
        sha_pkg::UPDATE: begin
          chain_q[0] <= chain_q[0] + a_q;
          chain_q[1] <= chain_q[1] + b_q;
          chain_q[2] <= chain_q[2] + c_q;
          chain_q[3] <= chain_q[3] + d_q;
          chain_q[4] <= chain_q[4] + e_q;
          chain_q[5] <= chain_q[5] + f_q;
          chain_q[6] <= chain_q[6] + g_q;
          chain_q[7] <= chain_q[7] + h_q;
          valid_q    <= 1'b1;
          state_q    <= sha_pkg::IDLE;
        end
        default: state_q <= sha_pkg::IDLE;
      endcase
    end
  end

  // working variables and schedule
  always_ff @(posedge clk_100mhz) begin
    if (take_o) begin
      a_q <= chain_src[0];
      b_q <= chain_src[1];
      c_q <= chain_src[2];
      d_q <= chain_src[3];
      e_q <= chain_src[4];
      f_q <= chain_src[5];
      g_q <= chain_src[6];
      h_q <= chain_src[7];
      w_q <= block_i;                      // W0 from the top word
    end else if (state_q == sha_pkg::ROUND) begin
      h_q <= g_q;
      g_q <= f_q;
      f_q <= e_q;
      e_q <= d_q + t1;
      d_q <= c_q;
      c_q <= b_q;
      b_q <= a_q;
      a_q <= t1 + t2;
      w_q <= {w_q[1:15], w_next};          // slide window by one word
    end
  end

  // every new hash comes from a block taken 66 cycles before
  a_valid_from_take : assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    $rose(valid_o) |-> $past(take_o, 66));

endmodule

// ==== rtl/sha_coproc_top.sv ====
`timescale 1ns/1ns

module sha_coproc_top #(
  parameter logic [31:0] BUILD_DATE = 32'h16072401
) (
  input  logic                  clk_100mhz,
  input  logic                  rstn_i,
  input  sha_pkg::sys_bus_req_t bus_req_i,
  output sha_pkg::sys_bus_rsp_t bus_rsp_o,
  output logic                  activated_o
);

  logic                 sha_run;      // reset of assembler and core, active low
  logic                 push_valid;
  logic [31:0]          push_word;
  logic                 blk_full;
  logic                 blk_empty;
  logic [511:0]         block;
  logic                 blk_take;
  logic                 start;
  logic                 ready;
  logic                 hash_valid;
  logic [255:0]         hash;
  sha_pkg::sha_status_t sha_status;

  assign sha_status = '{ready: ready, hash_valid: hash_valid,
                        blk_full: blk_full, blk_empty: blk_empty};

  // ----------------------------------------------------------------------
  // register file and bus slave
  // ----------------------------------------------------------------------

  sys_bus_regs #(
    .BUILD_DATE (BUILD_DATE)
  ) u_regs (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn_i),
    .bus_req_i    (bus_req_i),
    .sha_status_i (sha_status),
    .hash_i       (hash),
    .bus_rsp_o    (bus_rsp_o),
    .activated_o  (activated_o),
    .sha_run_o    (sha_run),
    .start_o      (start),
    .push_valid_o (push_valid),
    .push_word_o  (push_word)
  );

  block_assembler u_blk (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (sha_run),
    .push_valid_i (push_valid),
    .push_word_i  (push_word),
    .take_i       (blk_take),
    .block_o      (block),
    .full_o       (blk_full),
    .empty_o      (blk_empty)
  );

  sha256_core u_core (
    .clk_100mhz (clk_100mhz),
    .rstn_i     (sha_run),
    .start_i    (start),
    .block_i    (block),
    .full_i     (blk_full),
    .take_o     (blk_take),
    .ready_o    (ready),
    .valid_o    (hash_valid),
    .hash_o     (hash)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o  = 1'b0;
    rstn_o = 1'b0;              // held for two rising edges
    repeat (2) @(posedge clk_o);
    #1 rstn_o = 1'b1;
  end

  always #5 clk_o = ~clk_o;     // 10 ns period

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker #(
  parameter logic [31:0] BUILD_DATE = 32'h0
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  sha_pkg::sys_bus_req_t bus_req_i,
  input  sha_pkg::sys_bus_rsp_t bus_rsp_i,
  output int                    err_cnt_o
);

  logic [31:0]      ctrl_exp;
  logic [31:0]      sha_ctrl_exp;
  logic [0:7][31:0] chain;         // model hash H0..H7
  logic [0:15][31:0] blk;
  int               n_words;
  bit               hash_known;    // hash registers predictable
  bit               req_prev;
  bit               rd_pend;
  logic [19:0]      rd_addr;

  // ----------------------------------------------------------------------
  // reference SHA-256 compression
  // ----------------------------------------------------------------------

  function automatic logic [31:0] ror(input logic [31:0] x, input int n);
    logic [63:0] d;
    d = {x, x} >> n;              // rotate through a doubled word
    return d[31:0];
  endfunction

  function automatic logic [0:7][31:0] compress(input logic [0:7][31:0] h,
                                                input logic [0:15][31:0] m);
    logic [31:0] w [64];
    logic [31:0] v [8];
    logic [31:0] s0, s1, tmp1, tmp2;
    logic [0:7][31:0] r;
    for (int t = 0; t < 64; t++) begin
      if (t < 16) begin
        w[t] = m[t];
      end else begin
        s0   = ror(w[t-15], 7) ^ ror(w[t-15], 18) ^ (w[t-15] >> 3);
        s1   = ror(w[t-2], 17) ^ ror(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
      end
    end
    for (int i = 0; i < 8; i++) v[i] = h[i];
    for (int t = 0; t < 64; t++) begin
      s1   = ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25);
      tmp1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha_pkg::SHA_K[t] + w[t];
      s0   = ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22);
      tmp2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--) v[i] = v[i-1];
      v[4] = v[4] + tmp1;         // d + t1, d already moved into slot 4
      v[0] = tmp1 + tmp2;
    end
    for (int i = 0; i < 8; i++) r[i] = h[i] + v[i];
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // monitor, sampled mid cycle where bus and responses are stable
  // ----------------------------------------------------------------------

  always @(negedge clk_i) begin
    logic [31:0] exp_val;
    bit          known;
    logic [19:0] hoff;
    if (!rstn_i) begin
      ctrl_exp     = '0;
      sha_ctrl_exp = '0;
      chain        = sha_pkg::SHA_IV;
      n_words      = 0;
      hash_known   = 0;
      req_prev     = 0;
      rd_pend      = 0;
      err_cnt_o    = 0;
    end else begin
      if (bus_rsp_i.ack !== req_prev) begin
        err_cnt_o++;
        $display("Mismatch at %0t: ack %b, request in cycle before %b",
                 $time, bus_rsp_i.ack, req_prev);
      end
      if (bus_rsp_i.err !== 1'b0) begin
        err_cnt_o++;
        $display("Mismatch at %0t: err %b, expected 0", $time, bus_rsp_i.err);
      end
      if (rd_pend && bus_rsp_i.ack) begin
        known   = 1;
        exp_val = '0;             // unmapped default
        hoff    = rd_addr - sha_pkg::REG_SHA_HASH_BASE;
        case (rd_addr)
          sha_pkg::REG_CTRL:       exp_val = ctrl_exp;
          sha_pkg::REG_VERSION:    exp_val = BUILD_DATE;
          sha_pkg::REG_SHA_CTRL:   exp_val = sha_ctrl_exp;
          sha_pkg::REG_STATUS,
          sha_pkg::REG_SHA_STATUS: known = 0;   // checked by the sequence
          default: begin
            if (hoff < 20'd32 && hoff[1:0] == 2'b00) begin
              known   = hash_known;
              exp_val = chain[7 - int'(hoff[4:2])];  // H7 at the base
            end
          end
        endcase
        if (known && bus_rsp_i.rdata !== exp_val) begin
          err_cnt_o++;
          $display("Mismatch at %0t: addr %h read %h, expected %h",
                   $time, rd_addr, bus_rsp_i.rdata, exp_val);
        end
      end
      // shadow update from writes
      if (bus_req_i.wen) begin
        case (bus_req_i.addr)
          sha_pkg::REG_CTRL: begin
            ctrl_exp = bus_req_i.wdata;
            if (!bus_req_i.wdata[sha_pkg::CTRL_ENABLE]) begin
              n_words    = 0;       // sha section held in reset
              chain      = sha_pkg::SHA_IV;
              hash_known = 0;
            end
          end
          sha_pkg::REG_SHA_CTRL: begin
            sha_ctrl_exp = bus_req_i.wdata & ~32'hf;
            if (bus_req_i.wdata[sha_pkg::SHA_CTRL_RESET]) begin
              n_words    = 0;
              chain      = sha_pkg::SHA_IV;
              hash_known = 0;
            end else if (bus_req_i.wdata[sha_pkg::SHA_CTRL_START]) begin
              chain      = sha_pkg::SHA_IV;
              hash_known = 0;
            end
          end
          sha_pkg::REG_SHA_PUSH: begin
            if (ctrl_exp[sha_pkg::CTRL_ENABLE]) begin
              blk[n_words] = bus_req_i.wdata;
              n_words++;
              if (n_words == sha_pkg::BLOCK_WORDS) begin
                chain      = compress(chain, blk);  // chained onto last hash
                n_words    = 0;
                hash_known = 1;
              end
            end
          end
          default: ;
        endcase
      end
      req_prev = bus_req_i.wen || bus_req_i.ren;
      rd_pend  = bus_req_i.ren;
      rd_addr  = bus_req_i.addr;
    end
  end

endmodule

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

  localparam logic [31:0] BUILD_DATE = 32'h16072401;
  localparam int          POLL_LIMIT = 200;

  logic                  clk_100mhz;
  logic                  rstn;
  sha_pkg::sys_bus_req_t bus_req;
  sha_pkg::sys_bus_rsp_t bus_rsp;
  logic                  activated;
  logic [31:0]           lfsr_q;
  int                    chk_errs;
  int                    other_errs;
  bit                    aborted;     // a wait timed out, rest is skipped
  logic [31:0]           rd;
  bit                    seen_full;

  tb_clock_gen u_clk (.clk_o(clk_100mhz), .rstn_o(rstn));

  sha_coproc_top #(.BUILD_DATE(BUILD_DATE)) UUT (
    .clk_100mhz  (clk_100mhz),
    .rstn_i      (rstn),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .activated_o (activated)
  );

  tb_checker #(.BUILD_DATE(BUILD_DATE)) u_chk (
    .clk_i     (clk_100mhz),
    .rstn_i    (rstn),
    .bus_req_i (bus_req),
    .bus_rsp_i (bus_rsp),
    .err_cnt_o (chk_errs)
  );

  // ----------------------------------------------------------------------
  // random source, galois lfsr one step per bit
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // bus access
  // ----------------------------------------------------------------------

  task automatic bus_access(input logic [19:0] addr, input logic [31:0] data,
                            input bit is_wr, output logic [31:0] rdata);
    int n;
    rdata = '0;
    if (!aborted) begin
      @(posedge clk_100mhz);
      #1;
      bus_req.addr  = addr;
      bus_req.wdata = data;
      bus_req.wen   = is_wr;
      bus_req.ren   = !is_wr;
      @(posedge clk_100mhz);
      #1;
      bus_req.wen = 1'b0;
      bus_req.ren = 1'b0;
      n = 0;
      while (!bus_rsp.ack && n < 8) begin
        @(posedge clk_100mhz);
        #1;
        n++;
      end
      if (!bus_rsp.ack) begin
        other_errs++;
        aborted = 1;
        $display("no acknowledge for access to %h", addr);
      end
      rdata = bus_rsp.rdata;
    end
  endtask

  task automatic bus_write(input logic [19:0] addr, input logic [31:0] data);
    logic [31:0] dummy;
    bus_access(addr, data, 1'b1, dummy);
  endtask

  task automatic bus_read(input logic [19:0] addr, output logic [31:0] data);
    bus_access(addr, '0, 1'b0, data);
  endtask

  task automatic expect_bits(input string what, input logic [31:0] got,
                             input logic [31:0] mask, input logic [31:0] exp);
    if (!aborted && (got & mask) !== exp) begin
      other_errs++;
      $display("Mismatch at %0t: %s read %h, expected %h under mask %h",
               $time, what, got, exp, mask);
    end
  endtask

  // poll one SHA status bit until it takes a value
  task automatic wait_sha_status(input int bit_idx, input logic val);
    logic [31:0] s;
    int          n;
    n = 0;
    s = '0;
    bus_read(sha_pkg::REG_SHA_STATUS, s);
    while (!aborted && s[bit_idx] !== val && n < POLL_LIMIT) begin
      bus_read(sha_pkg::REG_SHA_STATUS, s);
      n++;
    end
    if (!aborted && s[bit_idx] !== val) begin
      other_errs++;
      aborted = 1;
      $display("timed out waiting for sha status bit %0d to become %b", bit_idx, val);
    end
  endtask

  task automatic push_block();
    logic [31:0] s;
    for (int i = 0; i < sha_pkg::BLOCK_WORDS; i++) begin
      bus_write(sha_pkg::REG_SHA_PUSH, rand_bits(32));
    end
    bus_read(sha_pkg::REG_SHA_STATUS, s);   // block still full here
    seen_full = s[6];
  endtask

  task automatic read_hash();
    logic [31:0] s;
    for (int i = 0; i < 8; i++) begin
      bus_read(sha_pkg::REG_SHA_HASH_BASE + 20'(4 * i), s);  // compared by checker
    end
  endtask

  // ----------------------------------------------------------------------
  // scenario
  // ----------------------------------------------------------------------

  initial begin
    int n;
    logic [31:0] v;
    bus_req    = '0;
    lfsr_q     = 32'hdb3aaece;
    other_errs = 0;
    aborted    = 0;
    seen_full  = 0;
    n = 0;
    while (rstn !== 1'b1 && n < 20) begin
      @(posedge clk_100mhz);
      n++;
    end
    if (rstn !== 1'b1) begin
      other_errs++;
      aborted = 1;
      $display("reset was never released");
    end
    // after reset
    bus_read(sha_pkg::REG_CTRL, rd);
    bus_read(sha_pkg::REG_SHA_CTRL, rd);
    bus_read(sha_pkg::REG_VERSION, rd);
    bus_read(sha_pkg::REG_STATUS, rd);
    expect_bits("status after reset", rd, 32'hffffffff, 32'h0);
    // register readback, enable bit kept off
    v = rand_bits(32) & ~32'h1;
    bus_write(sha_pkg::REG_CTRL, v);
    bus_read(sha_pkg::REG_CTRL, rd);
    bus_write(sha_pkg::REG_SHA_CTRL, rand_bits(32));
    bus_read(sha_pkg::REG_SHA_CTRL, rd);
    for (int i = 0; i < 4; i++) begin
      bus_read(20'h01000 | (20'(rand_bits(20)) & 20'h0fffc), rd);  // unmapped
    end
    // pushes while disabled are dropped
    bus_write(sha_pkg::REG_SHA_PUSH, rand_bits(32));
    bus_read(sha_pkg::REG_SHA_STATUS, rd);
    expect_bits("blk_empty while disabled", rd, 32'h10, 32'h10);
    // activation
    bus_write(sha_pkg::REG_CTRL, 32'h1);
    n = 0;
    while (!aborted && activated !== 1'b1 && n < 20) begin
      @(posedge clk_100mhz);
      #1;
      n++;
    end
    if (!aborted && activated !== 1'b1) begin
      other_errs++;
      aborted = 1;
      $display("activated_o never rose after enable");
    end
    bus_read(sha_pkg::REG_STATUS, rd);
    expect_bits("status after enable", rd, 32'h11, 32'h11);
    // first block from the IV
    bus_write(sha_pkg::REG_SHA_CTRL, 32'h2);
    push_block();
    if (!aborted && !seen_full) begin
      other_errs++;
      $display("blk_full not seen after sixteen pushes");
    end
    wait_sha_status(1, 1'b1);
    read_hash();
    // chained second block
    push_block();
    wait_sha_status(1, 1'b0);
    wait_sha_status(1, 1'b1);
    read_hash();
    // sha reset pulse
    bus_write(sha_pkg::REG_SHA_CTRL, 32'h1);
    bus_read(sha_pkg::REG_SHA_STATUS, rd);
    expect_bits("status after sha reset", rd, 32'h13, 32'h11);
    repeat (2) @(posedge clk_100mhz);
    $display("closing: %0d checker mismatches, %0d other errors", chk_errs, other_errs);
    if (chk_errs == 0 && other_errs == 0 && !aborted) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #1ms;
    $display("simulation ran too long and was stopped");
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
rtl/sha_pkg.sv
rtl/sys_bus_regs.sv
rtl/block_assembler.sv
rtl/sha256_core.sv
rtl/sha_coproc_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = sources.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
